//--- verilog/cpc_pkg.sv
////////////////////
// CPC expansion package
// Widths, SDRAM page numbers, Multiface shadow map,
// bus structs and the freezer state encoding
////////////////////
`default_nettype none

package cpc_pkg;

	typedef logic [7:0]   byte_t;
	typedef logic [15:0]  cpu_addr_t;
	typedef logic [22:0]  sdram_addr_t;   // Word address in one 8 MB bank
	typedef logic [24:0]  load_addr_t;
	typedef logic [1:0]   bank_t;
	typedef logic [8:0]   page_t;         // 16 KB page in the bank
	typedef logic [12:0]  mf2_addr_t;
	typedef logic [255:0] rom_map_t;      // One bit per upper ROM

	////////////////////
	// Loader image indices and SDRAM pages
	////////////////////
	localparam byte_t IDX_ROM = 8'd0;     // System ROM image
	localparam byte_t IDX_EXT = 8'd3;     // Expansion ROM image

	localparam page_t PAGE_OS        = 9'h000;
	localparam page_t PAGE_BASIC     = 9'h100;
	localparam page_t PAGE_AMSDOS    = 9'h107;
	localparam page_t PAGE_MF2       = 9'h0FF;
	localparam page_t PAGE_BAD_EXT   = 9'h1EE;  // Unused page for a malformed extension
	localparam page_t PAGE_COMBO_END = 9'h1FF;

	////////////////////
	// Multiface Two
	////////////////////
	localparam cpu_addr_t MF2_NMI_ENTRY  = 16'h0066;
	localparam cpu_addr_t MF2_HIDE_ENTRY = 16'h0065;
	localparam cpu_addr_t MF2_PORT_BASE  = 16'hFEE8;  // Bit 1 picks enable or disable

	// Where each hardware register lands in the Multiface RAM
	localparam mf2_addr_t SHD_PEN_IDX   = 13'h1FCF;
	localparam mf2_addr_t SHD_BORDER    = 13'h1FDF;
	localparam mf2_addr_t SHD_PEN_BASE  = 13'h1F90;
	localparam mf2_addr_t SHD_MODE      = 13'h1FEF;
	localparam mf2_addr_t SHD_BANK      = 13'h1FFF;
	localparam mf2_addr_t SHD_CRTC_SEL  = 13'h1CFF;
	localparam mf2_addr_t SHD_CRTC_BASE = 13'h1DB0;
	localparam mf2_addr_t SHD_PPI       = 13'h17FF;
	localparam mf2_addr_t SHD_UROM      = 13'h1AAC;

	// I/O port high bytes
	localparam byte_t PORT_GA       = 8'h7F;  // Gate array
	localparam byte_t PORT_CRTC_SEL = 8'hBC;
	localparam byte_t PORT_CRTC_DAT = 8'hBD;
	localparam byte_t PORT_PPI      = 8'hF7;  // 8255
	localparam byte_t PORT_UROM     = 8'hDF;  // Upper ROM select

	typedef struct packed {
		logic        wr;
		load_addr_t  addr;
		byte_t       data;
		logic        download;
		byte_t       index;
		logic [15:0] file_ext;   // Last two characters of the extension
	} load_req_t;

	typedef struct packed {
		cpu_addr_t addr;
		byte_t     dout;
		logic      m1;
		logic      io_wr;
		logic      mem_wr;
		logic      mem_rd;
	} cpu_bus_t;

	typedef struct packed {
		logic        oe;
		logic        we;
		bank_t       bank;
		sdram_addr_t addr;
		byte_t       data;
	} sdram_req_t;

	typedef enum logic [1:0] {
		MF2_IDLE,
		MF2_NMI_PENDING,
		MF2_PAGED_IN
	} mf2_state_t;

endpackage

`default_nettype wire

//--- verilog/rom_page_tracker.sv
////////////////////
// ROM page tracker
// Decodes the expansion page from the file extension,
// handles combo images and keeps the upper ROM map
////////////////////
`timescale 1ns/10ps
`default_nettype none

module rom_page_tracker (
	input  wire                  clk_sys,
	input  wire                  reset,
	input  wire cpc_pkg::load_req_t   load_i,
	input  wire cpc_pkg::sdram_addr_t boot_addr_i,
	output cpc_pkg::page_t       page_o,
	output cpc_pkg::rom_map_t    rom_map_o
);
	import cpc_pkg::*;

	logic       rom_load;
	logic       ext_load;
	logic       dl_q;
	logic       wr_q;
	logic       combo;
	logic [4:0] hi_dig;
	logic [4:0] lo_dig;
	page_t      ext_page;
	logic       ext_combo;

	// {valid, value} of one hex character
	function automatic logic [4:0] hex_digit(input byte_t c);
		logic [4:0] r;
		r = 5'd0;
		if (c >= "0" && c <= "9")
			r = {1'b1, c[3:0]};
		else if (c >= "A" && c <= "F")
			r = {1'b1, c[3:0] + 4'd9};
		return r;
	endfunction

	assign rom_load = load_i.download && (load_i.index == IDX_ROM);
	assign ext_load = load_i.download && (load_i.index == IDX_EXT);
	assign hi_dig   = hex_digit(load_i.file_ext[15:8]);
	assign lo_dig   = hex_digit(load_i.file_ext[7:0]);

	always_comb begin
		ext_page  = PAGE_BAD_EXT;
		ext_combo = 1'b0;
		if (hi_dig[4])
			ext_page[7:4] = hi_dig[3:0];
		if (lo_dig[4])
			ext_page[3:0] = lo_dig[3:0];
		if (load_i.file_ext == "ZZ")
			ext_page = '0;
		if (load_i.file_ext == "Z0") begin // Combo image starting at page 0
			ext_page  = '0;
			ext_combo = 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_q      <= 1'b0;
			wr_q      <= 1'b0;
			combo     <= 1'b0;
			page_o    <= PAGE_OS;
			rom_map_o <= '0;
		end else begin
			dl_q <= load_i.download;
			wr_q <= load_i.wr;
			// End of a byte write
			if ((rom_load | ext_load) & wr_q & ~load_i.wr) begin
				if (boot_addr_i[22])
					rom_map_o[boot_addr_i[21:14]] <= 1'b1;
				if (combo && &boot_addr_i[13:0]) begin
					combo  <= 1'b0;
					page_o <= PAGE_COMBO_END;
				end
			end
			if (ext_load & ~dl_q) begin
				page_o <= ext_page;
				combo  <= ext_combo;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/boot_addr_map.sv
////////////////////
// Boot address map
// Places loader bytes in SDRAM and picks the SDRAM request
// from the loader, the Multiface ROM or the CPU
////////////////////
`timescale 1ns/10ps
`default_nettype none

module boot_addr_map (
	input  wire cpc_pkg::load_req_t  load_i,
	input  wire cpc_pkg::page_t      page_i,
	input  wire                      model_i,
	input  wire                      mf2_rom_en_i,
	input  wire                      mf2_ram_en_i,
	input  wire cpc_pkg::cpu_bus_t   cpu_i,
	output cpc_pkg::sdram_addr_t     boot_addr_o,
	output cpc_pkg::sdram_req_t      sdram_o
);
	import cpc_pkg::*;

	logic        rom_load;
	logic        ext_load;
	logic        boot_wr;
	logic        mf2_sel;
	logic [10:0] seg;        // 16 KB segment of the loader offset
	bank_t       boot_bank;
	sdram_addr_t boot_a;

	assign rom_load = load_i.download && (load_i.index == IDX_ROM);
	assign ext_load = load_i.download && (load_i.index == IDX_EXT);
	assign seg      = load_i.addr[24:14];
	assign mf2_sel  = mf2_rom_en_i | mf2_ram_en_i;

	////////////////////
	// Loader placement
	////////////////////
	// Lower half of a bank holds OS, RAM and MF2 ROM, upper half the upper ROMs
	always_comb begin
		boot_wr       = (rom_load | ext_load) & load_i.wr;
		boot_a[13:0]  = load_i.addr[13:0];
		boot_a[22:14] = '1;
		boot_bank     = '0;
		if (ext_load) begin
			boot_a[22]    = page_i[8];
			boot_a[21:14] = page_i[7:0] + load_i.addr[21:14];
			boot_bank     = {1'b0, model_i};
		end else begin
			case (seg)
				11'd0, 11'd4: boot_a[22:14] = PAGE_OS;
				11'd1, 11'd5: boot_a[22:14] = PAGE_BASIC;
				11'd2, 11'd6: boot_a[22:14] = PAGE_AMSDOS;
				11'd3, 11'd7: boot_a[22:14] = PAGE_MF2;
				default:      boot_wr = 1'b0;    // Beyond both ROM sets
			endcase
			if (seg[10:3] == 8'd0)
				boot_bank = {1'b0, seg[2]};      // 6128 set, then 664 set
		end
	end

	assign boot_addr_o = boot_a;

	////////////////////
	// Request select
	////////////////////
	always_comb begin
		if (rom_load | ext_load) begin
			sdram_o.oe   = 1'b0;
			sdram_o.we   = boot_wr;
			sdram_o.bank = boot_bank;
			sdram_o.addr = boot_a;
			sdram_o.data = load_i.data;
		end else begin
			sdram_o.oe   = cpu_i.mem_rd & ~mf2_sel;
			sdram_o.we   = cpu_i.mem_wr & ~mf2_sel;
			sdram_o.bank = {1'b0, model_i};
			if (mf2_rom_en_i)
				sdram_o.addr = {PAGE_MF2, cpu_i.addr[13:0]};  // MF2 ROM image
			else
				sdram_o.addr = {7'd0, cpu_i.addr};
			sdram_o.data = cpu_i.dout;
		end
	end

endmodule

`default_nettype wire

//--- verilog/mf2_control.sv
////////////////////
// Multiface Two control
// NMI request, page-in on the NMI fetch, hide,
// and the enable and disable ports
////////////////////
`timescale 1ns/10ps
`default_nettype none

module mf2_control (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire cpc_pkg::cpu_bus_t cpu_i,
	input  wire                    key_nmi_i,
	input  wire [1:0]              mf2_mode_i,   // 0 enabled, 1 hidden, 2 disabled
	output logic                   nmi_o,
	output logic                   mf2_rom_en_o,
	output logic                   mf2_ram_en_o
);
	import cpc_pkg::*;

	mf2_state_t state;
	logic       hidden;
	logic       key_q;
	logic       m1_q;
	logic       io_wr_q;
	logic       key_rise;
	logic       m1_rise;
	logic       io_rise;
	logic       port_hit;
	logic       disabled;

	assign key_rise = key_nmi_i & ~key_q;
	assign m1_rise  = cpu_i.m1 & ~m1_q;
	assign io_rise  = cpu_i.io_wr & ~io_wr_q;
	assign port_hit = cpu_i.addr[15:2] == MF2_PORT_BASE[15:2];  // FEE8 or FEEA
	assign disabled = mf2_mode_i[1];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state   <= MF2_IDLE;
			hidden  <= |mf2_mode_i;
			key_q   <= 1'b0;
			m1_q    <= 1'b0;
			io_wr_q <= 1'b0;
		end else begin
			key_q   <= key_nmi_i;
			m1_q    <= cpu_i.m1;
			io_wr_q <= cpu_i.io_wr;
			case (state)
				MF2_IDLE:
					if (key_rise & ~disabled)
						state <= MF2_NMI_PENDING;
				MF2_NMI_PENDING:
					if (m1_rise && cpu_i.addr == MF2_NMI_ENTRY) begin
						state  <= MF2_PAGED_IN;
						hidden <= 1'b0;
					end
				MF2_PAGED_IN:
					if (m1_rise && cpu_i.addr == MF2_HIDE_ENTRY)
						hidden <= 1'b1;    // Exit through the hide vector
				default: state <= MF2_IDLE;
			endcase
			if (io_rise & port_hit) begin
				if (~cpu_i.addr[1] & ~hidden & ~disabled)
					state <= MF2_PAGED_IN;
				else if (state == MF2_PAGED_IN)
					state <= MF2_IDLE;
			end
		end
	end

	assign nmi_o        = state == MF2_NMI_PENDING;
	assign mf2_rom_en_o = (state == MF2_PAGED_IN) && (cpu_i.addr[15:13] == 3'b000);
	assign mf2_ram_en_o = (state == MF2_PAGED_IN) && (cpu_i.addr[15:13] == 3'b001);

endmodule

`default_nettype wire

//--- verilog/mf2_shadow_ram.sv
////////////////////
// Multiface Two RAM
// 8 KB RAM that also keeps copies of the gate array,
// CRTC, 8255 and upper ROM select writes
////////////////////
`timescale 1ns/10ps
`default_nettype none

module mf2_shadow_ram (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire cpc_pkg::cpu_bus_t cpu_i,
	input  wire                    mf2_ram_en_i,
	output cpc_pkg::byte_t         mf2_rd_o
);
	import cpc_pkg::*;

	byte_t     ram [0:8191];
	byte_t     ram_q;
	byte_t     ram_din;
	mf2_addr_t ram_addr;
	logic      ram_we;
	mf2_addr_t store_addr;
	logic [4:0] pen_idx;     // Bit 4 selects the border
	logic [3:0] crtc_reg;
	logic      io_wr_q;
	logic      io_rise;
	logic      ga_pen_sel;

	assign io_rise    = cpu_i.io_wr & ~io_wr_q;
	assign ga_pen_sel = (cpu_i.addr[15:8] == PORT_GA) && (cpu_i.dout[7:6] == 2'b00);

	////////////////////
	// Shadow address decode
	////////////////////
	// The Multiface port pair decodes to no shadow address
	always_comb begin
		casez ({cpu_i.addr[15:8], cpu_i.dout[7:6]})
			{PORT_GA, 2'b00}:       store_addr = SHD_PEN_IDX;
			{PORT_GA, 2'b01}: begin // Pen or border colour
				if (pen_idx[4])
					store_addr = SHD_BORDER;
				else
					store_addr = {SHD_PEN_BASE[12:4], pen_idx[3:0]};
			end
			{PORT_GA, 2'b10}:       store_addr = SHD_MODE;
			{PORT_GA, 2'b11}:       store_addr = SHD_BANK;
			{PORT_CRTC_SEL, 2'b??}: store_addr = SHD_CRTC_SEL;
			{PORT_CRTC_DAT, 2'b??}: store_addr = {SHD_CRTC_BASE[12:4], crtc_reg};
			{PORT_PPI, 2'b??}:      store_addr = SHD_PPI;
			{PORT_UROM, 2'b??}:     store_addr = SHD_UROM;
			default:                store_addr = '0;
		endcase
	end

	////////////////////
	// RAM port select
	////////////////////
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q  <= 1'b0;
			ram_we   <= 1'b0;
			pen_idx  <= '0;
			crtc_reg <= '0;
		end else begin
			io_wr_q <= cpu_i.io_wr;
			if (io_rise & (store_addr != '0)) begin
				if (ga_pen_sel)
					pen_idx <= cpu_i.dout[4:0];
				if (cpu_i.addr[15:8] == PORT_CRTC_SEL)
					crtc_reg <= cpu_i.dout[3:0];
				ram_we <= 1'b1;                    // Register shadow write
			end else if (cpu_i.mem_wr & mf2_ram_en_i) begin
				ram_we <= 1'b1;
			end else begin
				ram_we <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		ram_din <= cpu_i.dout;
		if (io_rise & (store_addr != '0))
			ram_addr <= store_addr;
		else
			ram_addr <= cpu_i.addr[12:0];
	end

	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			ram[ram_addr] <= ram_din;
			ram_q         <= ram_din;   // Write data shows through
		end else begin
			ram_q <= ram[ram_addr];
		end
	end

	assign mf2_rd_o = (mf2_ram_en_i & cpu_i.mem_rd) ? ram_q : 8'hFF;

endmodule

`default_nettype wire

//--- verilog/cpc_expansion_top.sv
////////////////////
// CPC expansion top
// ROM loader and Multiface Two freezer
// in front of the SDRAM request
////////////////////
`timescale 1ns/10ps
`default_nettype none

module cpc_expansion_top (
	input  wire                      clk_sys,
	input  wire                      reset,
	input  wire cpc_pkg::load_req_t  load_i,
	input  wire cpc_pkg::cpu_bus_t   cpu_i,
	input  wire                      key_nmi_i,
	input  wire [1:0]                mf2_mode_i,
	input  wire                      model_i,      // 0 CPC 6128, 1 CPC 664
	output cpc_pkg::sdram_req_t      sdram_o,
	output cpc_pkg::rom_map_t        rom_map_o,
	output cpc_pkg::byte_t           mf2_rd_o,
	output logic                     nmi_o
);
	import cpc_pkg::*;

	sdram_addr_t boot_addr;
	page_t       page;
	logic        mf2_rom_en;
	logic        mf2_ram_en;

	rom_page_tracker tracker0 (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.load_i      (load_i),
		.boot_addr_i (boot_addr),
		.page_o      (page),
		.rom_map_o   (rom_map_o)
	);

	boot_addr_map addr_map0 (
		.load_i       (load_i),
		.page_i       (page),
		.model_i      (model_i),
		.mf2_rom_en_i (mf2_rom_en),
		.mf2_ram_en_i (mf2_ram_en),
		.cpu_i        (cpu_i),
		.boot_addr_o  (boot_addr),
		.sdram_o      (sdram_o)
	);

	mf2_control ctrl0 (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cpu_i        (cpu_i),
		.key_nmi_i    (key_nmi_i),
		.mf2_mode_i   (mf2_mode_i),
		.nmi_o        (nmi_o),
		.mf2_rom_en_o (mf2_rom_en),
		.mf2_ram_en_o (mf2_ram_en)
	);

	mf2_shadow_ram shadow0 (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cpu_i        (cpu_i),
		.mf2_ram_en_i (mf2_ram_en),
		.mf2_rd_o     (mf2_rd_o)
	);

endmodule

`default_nettype wire

//--- dv/tb_cpc_expansion.sv
////////////////////
// CPC expansion testbench
// Directed tests of the ROM loader placement,
// the expansion page decode and the Multiface Two
////////////////////
`timescale 1ns/10ps
`default_nettype none

module tb_cpc_expansion;
	import cpc_pkg::*;

	localparam int CLK_PERIOD      = 40;
	localparam int WATCHDOG_CYCLES = 2000;   // All tests need well under this

	logic       clk_sys;
	logic       reset;
	load_req_t  load;
	cpu_bus_t   cpu;
	logic       key_nmi;
	logic [1:0] mf2_mode;
	logic       model;
	sdram_req_t sdram;
	rom_map_t   rom_map;
	byte_t      mf2_rd;
	logic       nmi;

	cpc_expansion_top dut0 (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.load_i     (load),
		.cpu_i      (cpu),
		.key_nmi_i  (key_nmi),
		.mf2_mode_i (mf2_mode),
		.model_i    (model),
		.sdram_o    (sdram),
		.rom_map_o  (rom_map),
		.mf2_rd_o   (mf2_rd),
		.nmi_o      (nmi)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		abort_run("Timeout: the tests did not finish within the watchdog limit");
	end

	////////////////////
	// Checking
	////////////////////
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp)
			abort_run($sformatf("mismatch at %0t: %s expected 0x%0h got 0x%0h",
				$time, name, exp, got));
	endtask

	// System ROM segment to SDRAM page, the same order in both sets
	function automatic page_t rom_seg_page(input int s);
		case (s % 4)
			0:       return PAGE_OS;
			1:       return PAGE_BASIC;
			2:       return PAGE_AMSDOS;
			default: return PAGE_MF2;
		endcase
	endfunction

	////////////////////
	// Loader driver
	////////////////////
	task automatic start_download(input byte_t idx, input logic [15:0] ext);
		@(posedge clk_sys);
		load.download <= 1'b1;
		load.index    <= idx;
		load.file_ext <= ext;
		repeat (2) @(posedge clk_sys);   // Page settles after the start
	endtask

	task automatic end_download;
		@(posedge clk_sys);
		load.download <= 1'b0;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic write_byte(input load_addr_t offset, input byte_t data, input logic exp_we,
			input sdram_addr_t exp_addr, input bank_t exp_bank, input logic check_place);
		@(posedge clk_sys);
		load.addr <= offset;
		load.data <= data;
		load.wr   <= 1'b1;
		@(negedge clk_sys);
		check_value("sdram_o.we", 32'(sdram.we), 32'(exp_we));
		check_value("sdram_o.oe", 32'(sdram.oe), 32'(1'b0));
		if (check_place) begin
			check_value("sdram_o.addr", 32'(sdram.addr), 32'(exp_addr));
			check_value("sdram_o.bank", 32'(sdram.bank), 32'(exp_bank));
			check_value("sdram_o.data", 32'(sdram.data), 32'(data));
		end
		repeat (2) @(posedge clk_sys);
		load.wr <= 1'b0;                 // Address held through the falling edge
		repeat (2) @(posedge clk_sys);
	endtask

	////////////////////
	// CPU driver
	////////////////////
	task automatic cpu_release;
		@(posedge clk_sys);
		cpu.m1     <= 1'b0;
		cpu.io_wr  <= 1'b0;
		cpu.mem_wr <= 1'b0;
		cpu.mem_rd <= 1'b0;
	endtask

	task automatic cpu_pulse(input cpu_addr_t addr, input byte_t data, input logic is_io);
		@(posedge clk_sys);
		cpu.addr  <= addr;
		cpu.dout  <= data;
		cpu.io_wr <= is_io;
		cpu.m1    <= ~is_io;
		repeat (2) @(posedge clk_sys);
		cpu_release();
	endtask

	task automatic cpu_access(input cpu_addr_t addr, input byte_t data, input logic is_wr);
		@(posedge clk_sys);
		cpu.addr   <= addr;
		cpu.dout   <= data;
		cpu.mem_wr <= is_wr;
		cpu.mem_rd <= ~is_wr;
		@(negedge clk_sys);
	endtask

	task automatic check_cpu_read(input cpu_addr_t addr, input sdram_addr_t exp_addr,
			input logic exp_oe);
		cpu_access(addr, 8'h00, 1'b0);
		check_value("sdram_o.addr", 32'(sdram.addr), 32'(exp_addr));
		check_value("sdram_o.oe", 32'(sdram.oe), 32'(exp_oe));
		cpu_release();
	endtask

	task automatic read_mf2(input cpu_addr_t addr, input byte_t exp);
		cpu_access(addr, 8'h00, 1'b0);
		repeat (3) @(posedge clk_sys);   // Registered address, then registered data
		@(negedge clk_sys);
		check_value("mf2_rd_o", 32'(mf2_rd), 32'(exp));
		cpu_release();
	endtask

	// Freezer button, then the NMI fetch
	task automatic press_nmi;
		int n;
		n = 0;
		@(posedge clk_sys);
		key_nmi <= 1'b1;
		while (nmi !== 1'b1) begin
			if (n == 8)
				abort_run("NMI request was not raised after the freezer button");
			else begin
				@(negedge clk_sys);
				n++;
			end
		end
		@(posedge clk_sys);
		key_nmi <= 1'b0;
		cpu_pulse(MF2_NMI_ENTRY, 8'h00, 1'b0);
		@(negedge clk_sys);
		check_value("nmi_o", 32'(nmi), 32'(1'b0));
	endtask

	////////////////////
	// Tests
	////////////////////
	task automatic test_system_rom;
		start_download(IDX_ROM, 16'h0000);
		for (int s = 0; s < 8; s++)
			write_byte({s[10:0], 14'h0100}, byte_t'(8'h40 + s), 1'b1,
				{rom_seg_page(s), 14'h0100}, bank_t'(s / 4), 1'b1);
		write_byte(25'h0020000, 8'h77, 1'b0, '0, '0, 1'b0);   // Segment 8
		end_download();
	endtask

	task automatic decode_ext(input logic [15:0] ext, input page_t exp_page);
		start_download(IDX_EXT, ext);
		write_byte(25'h0000010, 8'hA5, 1'b1, {exp_page, 14'h0010}, {1'b0, model}, 1'b1);
		end_download();
	endtask

	task automatic test_expansion_decode;
		check_value("rom_map_o[0x1A]", 32'(rom_map[8'h1A]), 32'(1'b0));
		decode_ext("1A", 9'h11A);
		check_value("rom_map_o[0x1A]", 32'(rom_map[8'h1A]), 32'(1'b1));
		decode_ext("F3", 9'h1F3);
		decode_ext("G7", 9'h1E7);       // Only the low digit is valid
		decode_ext("ZZ", 9'h000);
	endtask

	task automatic test_combo;
		start_download(IDX_EXT, "Z0");
		write_byte(25'h0003FFF, 8'h11, 1'b1, {9'h000, 14'h3FFF}, {1'b0, model}, 1'b1);
		write_byte(25'h0000123, 8'h22, 1'b1, {PAGE_COMBO_END, 14'h0123}, {1'b0, model}, 1'b1);
		end_download();
	endtask

	task automatic test_freezer_entry;
		press_nmi();
		check_cpu_read(16'h0123, {PAGE_MF2, 14'h0123}, 1'b0);
		cpu_pulse(MF2_HIDE_ENTRY, 8'h00, 1'b0);    // Hide on the way out
		cpu_pulse(16'hFEEA, 8'h00, 1'b1);
		check_cpu_read(16'h0123, 23'h000123, 1'b1);
		cpu_pulse(16'hFEE8, 8'h00, 1'b1);          // Ignored while hidden
		check_cpu_read(16'h0123, 23'h000123, 1'b1);
	endtask

	task automatic test_shadowing;
		cpu_pulse(16'h7F00, 8'h8C, 1'b1);          // Gate array mode
		cpu_pulse(16'hBC00, 8'h05, 1'b1);          // CRTC register select
		press_nmi();
		read_mf2({3'b001, SHD_MODE}, 8'h8C);
		read_mf2({3'b001, SHD_CRTC_SEL}, 8'h05);
		read_mf2(16'h4000, 8'hFF);
	endtask

	task automatic test_mf2_ram;
		cpu_access(16'h2010, 8'h5A, 1'b1);
		check_value("sdram_o.we", 32'(sdram.we), 32'(1'b0));
		repeat (2) @(posedge clk_sys);
		cpu_release();
		read_mf2(16'h2010, 8'h5A);
	endtask

	initial begin
		reset    <= 1'b1;
		load     <= '0;
		cpu      <= '0;
		key_nmi  <= 1'b0;
		mf2_mode <= 2'd0;                // Enabled, so not hidden after reset
		model    <= 1'b0;
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;
		@(posedge clk_sys);
		test_system_rom();
		test_expansion_decode();
		test_combo();
		test_freezer_entry();
		test_shadowing();
		test_mf2_ram();
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
verilog/cpc_pkg.sv
verilog/rom_page_tracker.sv
verilog/boot_addr_map.sv
verilog/mf2_control.sv
verilog/mf2_shadow_ram.sv
verilog/cpc_expansion_top.sv
dv/tb_cpc_expansion.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the CPC expansion testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_cpc_expansion -f files.f -o tb_sim

output=$(./obj_dir/tb_sim 2>&1 || true)
echo "$output"

if echo "$output" | grep -q "Test completed successfully"; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
